//--- Makefile
VERILATOR  ?= verilator
TOP        := bm_accum_tb
FLIST      := vlog.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bm_path/bm_color_update.sv
`include "bm_params.svh"

module bm_color_update (
  input  logic               clk,
  input  logic               rst_n,
  input  bm_color_pkg::rgb_t op_b,
  input  bm_color_pkg::rgb_t op_m,
  input  bm_color_pkg::rgb_t op_direct,
  output bm_color_pkg::rgb_t new_b
);

  localparam int W = `BM_CHAN_W;

  logic [2:0][W-1:0] m_ch;
  logic [2:0][W-1:0] d_ch;
  logic [2:0][W-1:0] prod_q;
  logic [2:0][W-1:0] b_q;
  logic [2:0][W-1:0] sum_q;
  logic [2:0][W:0]   sum;

  assign m_ch = op_m;
  assign d_ch = op_direct;

  // Stage one, upper half of M times direct
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_q <= '0;
    end else begin
      for (int i = 0; i < 3; i++) prod_q[i] <= W'((2*W)'(m_ch[i]) * d_ch[i] >> W);
    end
  end

  always_ff @(posedge clk) b_q <= op_b;

  // Stage two, add and clamp at one
  always_comb begin
    for (int i = 0; i < 3; i++) sum[i] = {1'b0, b_q[i]} + {1'b0, prod_q[i]};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q <= '0;
    end else begin
      for (int i = 0; i < 3; i++) sum_q[i] <= sum[i][W] ? `BM_ONE : sum[i][W-1:0];
    end
  end

  assign new_b = sum_q;

endmodule

//--- bm_path/bm_throughput_update.sv
`include "bm_params.svh"

module bm_throughput_update (
  input  logic                clk,
  input  logic                rst_n,
  input  bm_color_pkg::rgb_t  op_m,
  input  bm_color_pkg::chan_t op_spec,
  output bm_color_pkg::rgb_t  new_m
);

  localparam int W = `BM_CHAN_W;

  logic [2:0][W-1:0] m_ch;
  logic [2:0][W-1:0] prod_q;
  logic [2:0][W-1:0] hold_q;

  assign m_ch = op_m;

  // Same scalar factor for all three channels
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_q <= '0;
      hold_q <= '0;
    end else begin
      for (int i = 0; i < 3; i++) prod_q[i] <= W'((2*W)'(m_ch[i]) * op_spec >> W);
      hold_q <= prod_q; // Match the add stage of the color path
    end
  end

  assign new_m = hold_q;

endmodule

//--- common/bm_color_pkg.sv
`include "bm_params.svh"

package bm_color_pkg;

  // One Q0.16 channel
  typedef logic [`BM_CHAN_W-1:0] chan_t;

  typedef struct packed {
    chan_t red;
    chan_t green;
    chan_t blue;
  } rgb_t;

endpackage

//--- common/bm_params.svh
`ifndef BM_PARAMS_SVH
`define BM_PARAMS_SVH

// Color channel, unsigned Q0.16
`define BM_CHAN_W 16

// Ray ids and table size
`define BM_RAY_W 4
`define BM_NUM_RAYS 16

// Edges from acceptance to table write
`define BM_PIPE_DEPTH 4

// Done queue
`define BM_FIFO_DEPTH 8
`define BM_FREE_W $clog2(`BM_FIFO_DEPTH + 1)

// Q0.16 one, saturated
`define BM_ONE 16'hFFFF

`endif

//--- common/bm_ray_pkg.sv
`include "bm_params.svh"

package bm_ray_pkg;

  typedef logic [`BM_RAY_W-1:0] ray_id_t;

  // Travels alongside the data through the update pipeline
  typedef struct packed {
    ray_id_t ray_id;
    logic    is_last;
  } tag_t;

  // Finished ray as handed downstream
  typedef struct packed {
    ray_id_t            ray_id;
    bm_color_pkg::rgb_t color;
  } done_t;

endpackage

//--- dv/bm_accum_tb.sv
`include "bm_params.svh"

module bm_accum_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_RAYS = `BM_NUM_RAYS;
  localparam int SEED = 74887;
  // Two cycles per init, then 1 + 5 + 4 + 3 + 6 bounces per ray
  localparam int STIM_CYCLES = NUM_RAYS * (2 + 1 + 5 + 4 + 3 + 6);
  localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 200;

  logic                clk;
  logic                rst_n;
  logic                in_valid;
  bm_ray_pkg::ray_id_t in_ray_id;
  logic                in_is_last;
  bm_color_pkg::rgb_t  in_direct;
  bm_color_pkg::chan_t in_spec;
  logic                in_stall;
  logic                is_init;
  bm_ray_pkg::ray_id_t init_ray_id;
  logic                done_valid;
  bm_ray_pkg::ray_id_t done_ray_id;
  bm_color_pkg::rgb_t  done_color;
  logic                done_stall;
  int                  errors;
  int                  records;
  int                  pending;
  logic                timed_out;
  int unsigned         seed;
  logic                stall_on;
  int                  err_base;
  int                  rec_base;

  tb_clock u_clock (.clk, .rst_n);

  bm_accum UUT (
    .clk, .rst_n,
    .in_valid, .in_ray_id, .in_is_last, .in_direct, .in_spec, .in_stall,
    .is_init, .init_ray_id,
    .done_valid, .done_ray_id, .done_color, .done_stall
  );

  bm_checker #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_checker (
    .clk, .rst_n,
    .in_valid, .in_ray_id, .in_is_last, .in_direct, .in_spec, .in_stall,
    .is_init, .init_ray_id,
    .done_valid, .done_ray_id, .done_color, .done_stall,
    .errors, .records, .pending, .timed_out
  );

  function automatic int unsigned lcg_step(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [15:0] rand16();
    seed = lcg_step(seed);
    return seed[30:15];
  endfunction

  task automatic send_sample(input bm_ray_pkg::ray_id_t id, input logic last,
                             input bm_color_pkg::rgb_t direct,
                             input bm_color_pkg::chan_t spec);
    in_valid   <= 1'b1;
    in_ray_id  <= id;
    in_is_last <= last;
    in_direct  <= direct;
    in_spec    <= spec;
    @(posedge clk);
    while (in_stall) @(posedge clk); // Hold until accepted
  endtask

  task automatic init_all();
    for (int r = 0; r < NUM_RAYS; r++) begin
      is_init     <= 1'b1;
      init_ray_id <= bm_ray_pkg::ray_id_t'(r);
      @(posedge clk);
      is_init <= 1'b0;
      @(posedge clk);
    end
  endtask

  // Round robin over all rays keeps each id well apart
  task automatic run_rays(input int bounces, input logic [15:0] floor_v);
    bm_color_pkg::rgb_t  direct;
    bm_color_pkg::chan_t spec;
    @(posedge clk);
    for (int b = 0; b < bounces; b++) begin
      for (int r = 0; r < NUM_RAYS; r++) begin
        direct.red   = rand16() | floor_v;
        direct.green = rand16() | floor_v;
        direct.blue  = rand16() | floor_v;
        spec         = rand16() | floor_v;
        send_sample(bm_ray_pkg::ray_id_t'(r), b == bounces - 1, direct, spec);
      end
    end
    in_valid <= 1'b0;
  endtask

  task automatic finish_test(input int num, input string name);
    @(posedge clk);
    while (pending != 0) @(posedge clk);
    @(negedge clk); // Counts are stable away from the rising edge
    $display("test %0d %s: %0d records, %0d errors, %s", num, name,
             records - rec_base, errors - err_base, (errors == err_base) ? "ok" : "failed");
    err_base = errors;
    rec_base = records;
  endtask

  // Downstream stall held for stretches of random length
  initial begin : stall_gen
    int unsigned s;
    int          left;
    s = SEED;
    left = 0;
    done_stall = 1'b0;
    forever begin
      @(posedge clk);
      if (!stall_on) begin
        done_stall <= 1'b0;
        left = 0;
      end else if (left == 0) begin
        s = lcg_step(s);
        done_stall <= s[29];
        left = 3 + int'(s[25:22]);
      end else begin
        left--;
      end
    end
  end

  initial begin : watchdog
    wait (timed_out === 1'b1);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : main
    seed        = SEED;
    in_valid    = 1'b0;
    in_ray_id   = '0;
    in_is_last  = 1'b0;
    in_direct   = '0;
    in_spec     = '0;
    is_init     = 1'b0;
    init_ray_id = '0;
    stall_on    = 1'b0;
    err_base    = 0;
    rec_base    = 0;
    @(posedge rst_n);
    @(posedge clk);

    init_all();
    run_rays(1, 16'h0000);
    finish_test(1, "init and single last sample");

    run_rays(5, 16'h0000);
    finish_test(2, "interleaved multi-bounce");

    run_rays(4, 16'hF000); // Big light and throughput force clamping
    finish_test(3, "saturation");

    run_rays(3, 16'h0000);
    finish_test(4, "restart after last");

    stall_on <= 1'b1;
    run_rays(6, 16'h0000);
    stall_on <= 1'b0;
    finish_test(5, "random done stall");

    $display("summary: 5 tests, %0d records, %0d errors", records, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- dv/bm_checker.sv
`include "bm_params.svh"

module bm_checker #(
  parameter int TIMEOUT_CYCLES = 1000
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  bm_ray_pkg::ray_id_t in_ray_id,
  input  logic                in_is_last,
  input  bm_color_pkg::rgb_t  in_direct,
  input  bm_color_pkg::chan_t in_spec,
  input  logic                in_stall,
  input  logic                is_init,
  input  bm_ray_pkg::ray_id_t init_ray_id,
  input  logic                done_valid,
  input  bm_ray_pkg::ray_id_t done_ray_id,
  input  bm_color_pkg::rgb_t  done_color,
  input  logic                done_stall,
  output int                  errors,
  output int                  records,
  output int                  pending,
  output logic                timed_out
);
  timeunit 1ns;
  timeprecision 100ps;

  bm_color_pkg::rgb_t model_b [`BM_NUM_RAYS];
  bm_color_pkg::rgb_t model_m [`BM_NUM_RAYS];
  bm_ray_pkg::done_t  exp_q [$];
  int                 cycles;
  logic               reset_seen;

  // Q0.16 product keeps the upper half
  function automatic bm_color_pkg::chan_t q16_mul(input bm_color_pkg::chan_t a,
                                                  input bm_color_pkg::chan_t b);
    logic [31:0] p;
    p = 32'(a) * 32'(b);
    return p[31:16];
  endfunction

  function automatic bm_color_pkg::chan_t sat_add(input bm_color_pkg::chan_t a,
                                                  input bm_color_pkg::chan_t b);
    logic [16:0] s;
    s = 17'(a) + 17'(b);
    return (s > 17'h0FFFF) ? 16'hFFFF : s[15:0];
  endfunction

  // Expected gathered color after one bounce
  function automatic bm_color_pkg::rgb_t bounce_b(input bm_color_pkg::rgb_t b,
                                                  input bm_color_pkg::rgb_t m,
                                                  input bm_color_pkg::rgb_t d);
    bm_color_pkg::rgb_t r;
    r.red   = sat_add(b.red,   q16_mul(m.red,   d.red));
    r.green = sat_add(b.green, q16_mul(m.green, d.green));
    r.blue  = sat_add(b.blue,  q16_mul(m.blue,  d.blue));
    return r;
  endfunction

  function automatic bm_color_pkg::rgb_t bounce_m(input bm_color_pkg::rgb_t m,
                                                  input bm_color_pkg::chan_t spec);
    bm_color_pkg::rgb_t r;
    r.red   = q16_mul(m.red,   spec);
    r.green = q16_mul(m.green, spec);
    r.blue  = q16_mul(m.blue,  spec);
    return r;
  endfunction

  initial begin
    errors     = 0;
    records    = 0;
    pending    = 0;
    timed_out  = 1'b0;
    cycles     = 0;
    reset_seen = 1'b0;
  end

  always @(posedge clk) begin
    bm_color_pkg::rgb_t nb;
    bm_color_pkg::rgb_t nm;
    bm_ray_pkg::done_t  want;
    if (rst_n) begin
      if (!reset_seen) begin
        reset_seen = 1'b1;
        if (done_valid || in_stall) begin
          errors++;
          $display("ERR %0t: after reset done_valid=%b in_stall=%b", $time, done_valid, in_stall);
        end
      end
      cycles++;
      if (cycles >= TIMEOUT_CYCLES && !timed_out) begin
        $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        timed_out = 1'b1;
      end
      if (is_init) begin
        model_b[init_ray_id] = '0;
        model_m[init_ray_id] = {`BM_ONE, `BM_ONE, `BM_ONE};
      end
      if (in_valid && !in_stall) begin
        nb = bounce_b(model_b[in_ray_id], model_m[in_ray_id], in_direct);
        nm = bounce_m(model_m[in_ray_id], in_spec);
        if (in_is_last) begin
          want.ray_id = in_ray_id;
          want.color  = nb;
          exp_q.push_back(want);
          model_b[in_ray_id] = '0; // Ray starts over
          model_m[in_ray_id] = {`BM_ONE, `BM_ONE, `BM_ONE};
        end else begin
          model_b[in_ray_id] = nb;
          model_m[in_ray_id] = nm;
        end
      end
      if (done_valid && !done_stall) begin
        records++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERR %0t: unexpected record for ray %0d", $time, done_ray_id);
        end else begin
          want = exp_q.pop_front();
          if (done_ray_id !== want.ray_id || done_color !== want.color) begin
            errors++;
            $display("ERR %0t: got ray %0d color %h, expected ray %0d color %h",
                     $time, done_ray_id, done_color, want.ray_id, want.color);
          end
        end
      end
      pending <= exp_q.size();
    end
  end

endmodule

//--- dv/tb_clock.sv
module tb_clock #(
  parameter int HALF_PERIOD = 2,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1; // Released on an edge like any other input
  end

endmodule

//--- hw/bm_accum.sv
`include "bm_params.svh"

module bm_accum (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  bm_ray_pkg::ray_id_t  in_ray_id,
  input  logic                 in_is_last,
  input  bm_color_pkg::rgb_t   in_direct,
  input  bm_color_pkg::chan_t  in_spec,
  output logic                 in_stall,
  input  logic                 is_init,
  input  bm_ray_pkg::ray_id_t  init_ray_id,
  output logic                 done_valid,
  output bm_ray_pkg::ray_id_t  done_ray_id,
  output bm_color_pkg::rgb_t   done_color,
  input  logic                 done_stall
);

  bm_ray_pkg::ray_id_t   rd_addr;
  bm_ray_pkg::ray_id_t   wr_addr;
  bm_color_pkg::rgb_t    rd_b, rd_m;
  bm_color_pkg::rgb_t    wr_b, wr_m;
  bm_color_pkg::rgb_t    op_b, op_m, op_direct;
  bm_color_pkg::chan_t   op_spec;
  bm_color_pkg::rgb_t    new_b, new_m;
  bm_ray_pkg::tag_t      wb_tag;
  logic                  wb_valid;
  logic                  wr_en;
  logic [`BM_FREE_W-1:0] fifo_free;

  bm_issue u_issue (
    .clk, .rst_n,
    .in_valid, .in_ray_id, .in_is_last, .in_direct, .in_spec,
    .is_init, .in_stall,
    .rd_addr, .rd_b, .rd_m,
    .fifo_free,
    .op_valid (),  // Update paths run freely, validity rides in the tag pipeline
    .op_b, .op_m, .op_direct, .op_spec,
    .wb_valid, .wb_tag
  );

  bm_store u_store (
    .clk,
    .rd_addr, .rd_b, .rd_m,
    .wr_en, .wr_addr, .wr_b, .wr_m
  );

  bm_color_update u_color (
    .clk, .rst_n,
    .op_b, .op_m, .op_direct,
    .new_b
  );

  bm_throughput_update u_throughput (
    .clk, .rst_n,
    .op_m, .op_spec,
    .new_m
  );

  bm_retire u_retire (
    .clk, .rst_n,
    .wb_valid, .wb_tag, .new_b, .new_m,
    .is_init, .init_ray_id,
    .wr_en, .wr_addr, .wr_b, .wr_m,
    .fifo_free,
    .done_valid, .done_ray_id, .done_color, .done_stall
  );

endmodule

//--- hw/bm_issue.sv
`include "bm_params.svh"

module bm_issue (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        in_valid,
  input  bm_ray_pkg::ray_id_t         in_ray_id,
  input  logic                        in_is_last,
  input  bm_color_pkg::rgb_t          in_direct,
  input  bm_color_pkg::chan_t         in_spec,
  input  logic                        is_init,
  output logic                        in_stall,
  output bm_ray_pkg::ray_id_t         rd_addr,
  input  bm_color_pkg::rgb_t          rd_b,
  input  bm_color_pkg::rgb_t          rd_m,
  input  logic [`BM_FREE_W-1:0]       fifo_free,
  output logic                        op_valid,
  output bm_color_pkg::rgb_t          op_b,
  output bm_color_pkg::rgb_t          op_m,
  output bm_color_pkg::rgb_t          op_direct,
  output bm_color_pkg::chan_t         op_spec,
  output logic                        wb_valid,
  output bm_ray_pkg::tag_t            wb_tag
);

  localparam int FREE_W = `BM_FREE_W;
  localparam int TAG_STAGES = `BM_PIPE_DEPTH - 1;

  logic                accept;
  logic                cap_valid;
  bm_ray_pkg::tag_t    cap_tag;
  bm_color_pkg::rgb_t  cap_direct;
  bm_color_pkg::chan_t cap_spec;

  logic             valid_q [TAG_STAGES];
  bm_ray_pkg::tag_t tag_q   [TAG_STAGES];

  // Keep enough queue space for every sample that may still retire as last
  assign in_stall = is_init | (fifo_free < FREE_W'(`BM_PIPE_DEPTH + 1));
  assign accept   = in_valid & ~in_stall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_valid <= 1'b0;
      for (int i = 0; i < TAG_STAGES; i++) valid_q[i] <= 1'b0;
    end else begin
      cap_valid  <= accept;
      valid_q[0] <= cap_valid;
      for (int i = 1; i < TAG_STAGES; i++) valid_q[i] <= valid_q[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cap_tag.ray_id  <= in_ray_id;
      cap_tag.is_last <= in_is_last;
      cap_direct      <= in_direct;
      cap_spec        <= in_spec;
    end
    op_direct <= cap_direct; // lines up with the table read
    op_spec   <= cap_spec;
    tag_q[0]  <= cap_tag;
    for (int i = 1; i < TAG_STAGES; i++) tag_q[i] <= tag_q[i-1];
  end

  assign rd_addr  = cap_tag.ray_id;
  assign op_b     = rd_b;
  assign op_m     = rd_m;
  assign op_valid = valid_q[0];
  assign wb_valid = valid_q[TAG_STAGES-1];
  assign wb_tag   = tag_q[TAG_STAGES-1];

  // A ray must not be re-read before its earlier write has landed
  a_no_reaccept: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> !(cap_valid && cap_tag.ray_id == in_ray_id) &&
               !(valid_q[0] && tag_q[0].ray_id == in_ray_id) &&
               !(valid_q[1] && tag_q[1].ray_id == in_ray_id))
    else $error("ray %0d accepted while still in flight", in_ray_id);

endmodule

//--- hw/bm_retire.sv
`include "bm_params.svh"

module bm_retire (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wb_valid,
  input  bm_ray_pkg::tag_t      wb_tag,
  input  bm_color_pkg::rgb_t    new_b,
  input  bm_color_pkg::rgb_t    new_m,
  input  logic                  is_init,
  input  bm_ray_pkg::ray_id_t   init_ray_id,
  output logic                  wr_en,
  output bm_ray_pkg::ray_id_t   wr_addr,
  output bm_color_pkg::rgb_t    wr_b,
  output bm_color_pkg::rgb_t    wr_m,
  output logic [`BM_FREE_W-1:0] fifo_free,
  output logic                  done_valid,
  output bm_ray_pkg::ray_id_t   done_ray_id,
  output bm_color_pkg::rgb_t    done_color,
  input  logic                  done_stall
);

  localparam int DEPTH = `BM_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = `BM_FREE_W;

  logic               push;
  logic               pop;
  logic               restart;
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  bm_ray_pkg::done_t  fifo_mem [DEPTH];
  bm_ray_pkg::done_t  head;

  // Init and last both leave the entry at B = 0, M = one
  assign restart = is_init | (wb_valid & wb_tag.is_last);
  assign push    = wb_valid & wb_tag.is_last;
  assign pop     = done_valid & ~done_stall;

  always_comb begin
    wr_en   = is_init | wb_valid;
    wr_addr = is_init ? init_ray_id : wb_tag.ray_id;
    if (restart) begin
      wr_b = '0;
      wr_m = {`BM_ONE, `BM_ONE, `BM_ONE};
    end else begin
      wr_b = new_b;
      wr_m = new_m;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr].ray_id <= wb_tag.ray_id;
      fifo_mem[wr_ptr].color  <= new_b;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head        = fifo_mem[rd_ptr];
  assign done_valid  = (count != '0);
  assign done_ray_id = head.ray_id;
  assign done_color  = head.color;
  assign fifo_free   = CNT_W'(DEPTH) - count;

  // Credit stall upstream must leave room for every last sample in flight
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> count < CNT_W'(DEPTH))
    else $error("done queue overflow");

  a_init_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !(is_init && wb_valid))
    else $error("init while a sample retires");

endmodule

//--- hw/bm_store.sv
`include "bm_params.svh"

module bm_store (
  input  logic                  clk,
  input  bm_ray_pkg::ray_id_t   rd_addr,
  output bm_color_pkg::rgb_t    rd_b,
  output bm_color_pkg::rgb_t    rd_m,
  input  logic                  wr_en,
  input  bm_ray_pkg::ray_id_t   wr_addr,
  input  bm_color_pkg::rgb_t    wr_b,
  input  bm_color_pkg::rgb_t    wr_m
);

  // Gathered color and remaining throughput per ray
  bm_color_pkg::rgb_t b_mem [`BM_NUM_RAYS];
  bm_color_pkg::rgb_t m_mem [`BM_NUM_RAYS];

  // Same-edge read of a written address sees the old entry
  always_ff @(posedge clk) begin
    if (wr_en) begin
      b_mem[wr_addr] <= wr_b;
      m_mem[wr_addr] <= wr_m;
    end
    rd_b <= b_mem[rd_addr];
    rd_m <= m_mem[rd_addr];
  end

endmodule

//--- vlog.f
+incdir+common
common/bm_color_pkg.sv
common/bm_ray_pkg.sv
hw/bm_store.sv
hw/bm_issue.sv
bm_path/bm_color_update.sv
bm_path/bm_throughput_update.sv
hw/bm_retire.sv
hw/bm_accum.sv
dv/tb_clock.sv
dv/bm_checker.sv
dv/bm_accum_tb.sv
